//--- hdl/opl3_pkg.sv
// shared widths, vector types and waveform encoding for the FM operator RTL and testbench
package opl3_pkg;

    localparam int FNUM_WIDTH        = 10; // frequency number
    localparam int MULT_WIDTH        = 4;  // frequency multiplier
    localparam int BLOCK_WIDTH       = 3;  // octave
    localparam int WS_WIDTH          = 2;  // waveform select
    localparam int TL_WIDTH          = 3;  // total level, shift amount
    localparam int PHASE_WIDTH       = 20; // phase accumulator
    localparam int PHASE_INDEX_WIDTH = 8;  // top bits of accumulator
    localparam int SINE_WIDTH        = 12; // quarter-sine magnitude
    localparam int OP_OUT_WIDTH      = 13; // signed operator output

    localparam string SINE_FILE = "hdl/sine_quarter.hex"; // 64 entries, hex, one per line

    typedef logic [FNUM_WIDTH-1:0]        fnum_t;
    typedef logic [MULT_WIDTH-1:0]        mult_t;
    typedef logic [BLOCK_WIDTH-1:0]       block_t;
    typedef logic [TL_WIDTH-1:0]          tl_t;
    typedef logic [PHASE_WIDTH-1:0]       phase_t;
    typedef logic [PHASE_INDEX_WIDTH-1:0] phase_index_t;
    typedef logic [SINE_WIDTH-1:0]        sine_t;
    typedef logic signed [OP_OUT_WIDTH-1:0] op_out_t;

    typedef enum logic [WS_WIDTH-1:0] {
        WAVE_SINE       = 2'd0, // full sine
        WAVE_HALF_SINE  = 2'd1, // negative half zeroed
        WAVE_ABS_SINE   = 2'd2, // negative half folded up
        WAVE_PULSE_SINE = 2'd3  // rising quarters only
    } waveform_t;

endpackage

//--- hdl/phase_generator.sv
// producer stage: divides clk into a sample strobe and issues phase samples with valid/ready
`timescale 1ns/1ps

module phase_generator #(
    parameter int CLK_DIV_COUNT = 8 // system clocks per sample
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   kon,
    input  opl3_pkg::fnum_t        fnum,
    input  opl3_pkg::mult_t        mult,
    input  opl3_pkg::block_t       block,
    input  opl3_pkg::waveform_t    ws,
    input  opl3_pkg::tl_t          tl,
    output logic                   phase_valid,
    input  logic                   phase_ready,
    output opl3_pkg::phase_index_t phase_index,
    output opl3_pkg::waveform_t    phase_ws,
    output opl3_pkg::tl_t          phase_tl
);
    import opl3_pkg::*;

    localparam int DIV_WIDTH = (CLK_DIV_COUNT > 1) ? $clog2(CLK_DIV_COUNT) : 1;

    logic [DIV_WIDTH-1:0] div_count; // free running strobe divider
    logic                 strobe;
    logic                 accept;
    logic                 issue;
    phase_t               phase_acc;
    phase_t               phase_inc;

    assign strobe = (div_count == DIV_WIDTH'(CLK_DIV_COUNT - 1));
    assign accept = phase_valid && phase_ready;
    assign issue  = strobe && kon && !phase_valid; // only one sample pending at a time

    // fnum * mult << block, wraps mod 2^20
    assign phase_inc = (PHASE_WIDTH'(fnum) * PHASE_WIDTH'(mult)) << block;

    assign phase_index = phase_acc[PHASE_WIDTH-1 -: PHASE_INDEX_WIDTH]; // held until accept

    always_ff @(posedge clk) begin
        if (rst) begin
            div_count <= '0;
        end else if (strobe) begin
            div_count <= '0;
        end else begin
            div_count <= div_count + 1'b1;
        end
    end

    // pending flag and accumulator, both cleared on key-off
    always_ff @(posedge clk) begin
        if (rst || !kon) begin
            phase_valid <= 1'b0;
            phase_acc   <= '0;
        end else if (accept) begin
            phase_valid <= 1'b0;
            phase_acc   <= phase_acc + phase_inc; // advance only on transfer
        end else if (issue) begin
            phase_valid <= 1'b1;
        end
    end

    // settings captured with the sample
    always_ff @(posedge clk) begin
        if (issue) begin
            phase_ws <= ws;
            phase_tl <= tl;
        end
    end

    // sample held across a stall unless key-off flushes it
    assert property (@(posedge clk) disable iff (rst)
        phase_valid && !phase_ready && kon |=>
            phase_valid && $stable(phase_index) && $stable(phase_ws) && $stable(phase_tl))
        else $error("phase sample changed while stalled");

endmodule

//--- hdl/phase_fifo.sv
// buffer stage: small synchronous FIFO carrying phase index, waveform select and total level
`timescale 1ns/1ps

module phase_fifo #(
    parameter int FIFO_DEPTH = 4 // power of two
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  opl3_pkg::phase_index_t in_phase_index,
    input  opl3_pkg::waveform_t    in_ws,
    input  opl3_pkg::tl_t          in_tl,
    output logic                   out_valid,
    input  logic                   out_ready,
    output opl3_pkg::phase_index_t out_phase_index,
    output opl3_pkg::waveform_t    out_ws,
    output opl3_pkg::tl_t          out_tl
);
    import opl3_pkg::*;

    localparam int PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    phase_index_t index_mem [FIFO_DEPTH]; // payload storage
    waveform_t    ws_mem [FIFO_DEPTH];
    tl_t          tl_mem [FIFO_DEPTH];

    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [PTR_WIDTH:0]   count; // occupancy 0..FIFO_DEPTH
    logic                 push;
    logic                 pop;

    assign in_ready  = (count != (PTR_WIDTH+1)'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    assign out_phase_index = index_mem[rd_ptr]; // head of queue
    assign out_ws          = ws_mem[rd_ptr];
    assign out_tl          = tl_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            index_mem[wr_ptr] <= in_phase_index;
            ws_mem[wr_ptr]    <= in_ws;
            tl_mem[wr_ptr]    <= in_tl;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // idle or simultaneous push/pop
            endcase
        end
    end

    // a push into a full FIFO or a pop from an empty one pushes the count out of range
    assert property (@(posedge clk) disable iff (rst)
        count <= (PTR_WIDTH+1)'(FIFO_DEPTH))
        else $error("FIFO occupancy out of range");

    // empty and full both leave the pointers level
    assert property (@(posedge clk) disable iff (rst)
        (count == '0 || count == (PTR_WIDTH+1)'(FIFO_DEPTH)) |-> wr_ptr == rd_ptr)
        else $error("FIFO pointers disagree with occupancy");

endmodule

//--- hdl/waveform_generator.sv
// consumer stage: two-stage pipeline from phase index to attenuated signed operator sample
`timescale 1ns/1ps

module waveform_generator (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  opl3_pkg::phase_index_t in_phase_index,
    input  opl3_pkg::waveform_t    in_ws,
    input  opl3_pkg::tl_t          in_tl,
    output logic                   out_valid,
    input  logic                   out_ready,
    output opl3_pkg::op_out_t      out_sample
);
    import opl3_pkg::*;

    localparam int ADDR_WIDTH = PHASE_INDEX_WIDTH - 2; // low bits address the quarter table

    sine_t sine_rom [2**ADDR_WIDTH];

    initial begin
        $readmemh(SINE_FILE, sine_rom);
    end

    logic                  advance; // whole pipeline moves together
    logic [ADDR_WIDTH-1:0] rom_addr;
    logic                  s1_valid;
    sine_t                 s1_mag;
    logic                  s1_half;   // second half of the period
    logic                  s1_mirror; // falling quarter
    waveform_t             s1_ws;
    tl_t                   s1_tl;
    op_out_t               mag_ext;
    op_out_t               shaped;

    assign advance  = !(out_valid && !out_ready);
    assign in_ready = advance;

    // falling quarters read the table backwards
    assign rom_addr = in_phase_index[ADDR_WIDTH] ? ~in_phase_index[ADDR_WIDTH-1:0]
                                                 : in_phase_index[ADDR_WIDTH-1:0];

    // stage 1: table lookup, carry the shaping bits along
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s1_mag    <= sine_rom[rom_addr];
            s1_half   <= in_phase_index[ADDR_WIDTH+1];
            s1_mirror <= in_phase_index[ADDR_WIDTH];
            s1_ws     <= in_ws;
            s1_tl     <= in_tl;
        end
    end

    assign mag_ext = op_out_t'({1'b0, s1_mag}); // zero-extend, always positive

    // stage 2 shaping
    always_comb begin
        case (s1_ws)
            WAVE_SINE:       shaped = s1_half ? -mag_ext : mag_ext;
            WAVE_HALF_SINE:  shaped = s1_half ? '0 : mag_ext;
            WAVE_ABS_SINE:   shaped = mag_ext;
            WAVE_PULSE_SINE: shaped = s1_mirror ? '0 : mag_ext; // no sign flip
            default:         shaped = mag_ext;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out_sample <= shaped >>> s1_tl; // attenuation as arithmetic shift
        end
    end

    // output sample frozen until the sink takes it
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_sample))
        else $error("out_sample changed while stalled");

endmodule

//--- hdl/operator_top.sv
// top level of the FM operator: phase producer, FIFO buffer and waveform consumer
`timescale 1ns/1ps

module operator_top #(
    parameter int CLK_DIV_COUNT = 8, // clocks per sample strobe
    parameter int FIFO_DEPTH    = 4  // power of two
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                kon,
    input  opl3_pkg::fnum_t     fnum,
    input  opl3_pkg::mult_t     mult,
    input  opl3_pkg::block_t    block,
    input  opl3_pkg::waveform_t ws,
    input  opl3_pkg::tl_t       tl,
    output logic                out_valid,
    input  logic                out_ready,
    output opl3_pkg::op_out_t   out_sample
);
    import opl3_pkg::*;

    logic         phase_valid; // producer -> FIFO
    logic         phase_ready;
    phase_index_t phase_index;
    waveform_t    phase_ws;
    tl_t          phase_tl;

    logic         fifo_valid; // FIFO -> consumer
    logic         fifo_ready;
    phase_index_t fifo_phase_index;
    waveform_t    fifo_ws;
    tl_t          fifo_tl;

    phase_generator #(
        .CLK_DIV_COUNT(CLK_DIV_COUNT)
    ) u_phase_generator (
        .clk         (clk),
        .rst         (rst),
        .kon         (kon),
        .fnum        (fnum),
        .mult        (mult),
        .block       (block),
        .ws          (ws),
        .tl          (tl),
        .phase_valid (phase_valid),
        .phase_ready (phase_ready),
        .phase_index (phase_index),
        .phase_ws    (phase_ws),
        .phase_tl    (phase_tl)
    );

    phase_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_phase_fifo (
        .clk             (clk),
        .rst             (rst),
        .in_valid        (phase_valid),
        .in_ready        (phase_ready),
        .in_phase_index  (phase_index),
        .in_ws           (phase_ws),
        .in_tl           (phase_tl),
        .out_valid       (fifo_valid),
        .out_ready       (fifo_ready),
        .out_phase_index (fifo_phase_index),
        .out_ws          (fifo_ws),
        .out_tl          (fifo_tl)
    );

    waveform_generator u_waveform_generator (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (fifo_valid),
        .in_ready       (fifo_ready),
        .in_phase_index (fifo_phase_index),
        .in_ws          (fifo_ws),
        .in_tl          (fifo_tl),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_sample     (out_sample)
    );

endmodule

//--- test/operator_tb.sv
// self-checking testbench for operator_top with LFSR stimulus, reference model and watchdog
`timescale 1ns/1ps

module operator_tb;
    import opl3_pkg::*;

    localparam int CLK_DIV_COUNT   = 8;
    localparam int FIFO_DEPTH      = 4;
    localparam int CLK_PERIOD      = 20; // ns
    localparam int SAMPLES         = 64; // samples per tone
    localparam int NUM_RUNS        = 16; // tones over all tests
    localparam int WATCHDOG_CYCLES = NUM_RUNS * SAMPLES * CLK_DIV_COUNT * 4;
    localparam logic [31:0] LFSR_SEED = 32'hc49b;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003; // x^32 + x^22 + x^2 + x + 1

    logic      clk;
    logic      rst;
    logic      kon;
    fnum_t     fnum;
    mult_t     mult;
    block_t    block;
    waveform_t ws;
    tl_t       tl;
    logic      out_valid;
    logic      out_ready;
    op_out_t   out_sample;

    sine_t       sine_table [64]; // model copy of the quarter table
    logic [31:0] lfsr_state;
    int          phase_step;      // model increment per sample
    waveform_t   model_ws;
    tl_t         model_tl;
    int          rx_count;        // samples taken since key-on
    int          cycle;
    int          last_xfer;       // cycle of previous transfer
    logic        gap_check;       // spacing check for a free running sink
    logic        held_valid;      // sink stalled last cycle
    op_out_t     held_sample;
    op_out_t     expected;

    operator_top #(
        .CLK_DIV_COUNT(CLK_DIV_COUNT),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) DUT (
        .clk        (clk),
        .rst        (rst),
        .kon        (kon),
        .fnum       (fnum),
        .mult       (mult),
        .block      (block),
        .ws         (ws),
        .tl         (tl),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_sample (out_sample)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1); // galois step
    endfunction

    // msb first with one LFSR step per bit taken
    task automatic get_random(input int nbits, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < nbits; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // expected output for the n-th sample after key-on
    function automatic int model_sample(input int n);
        phase_t       phase;
        phase_index_t index;
        logic [5:0]   addr;
        int           mag;
        int           value;
        phase = PHASE_WIDTH'(longint'(n) * phase_step); // n * increment mod 2^20
        index = phase[PHASE_WIDTH-1 -: PHASE_INDEX_WIDTH];
        addr  = index[6] ? 6'(63 - index[5:0]) : index[5:0]; // falling quarter read backwards
        mag   = int'(sine_table[addr]);
        case (model_ws)
            WAVE_SINE:      value = index[7] ? -mag : mag;
            WAVE_HALF_SINE: value = index[7] ? 0 : mag;
            WAVE_ABS_SINE:  value = mag;
            default:        value = index[6] ? 0 : mag; // pulse sine never negative
        endcase
        return value >>> model_tl; // attenuation
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "stopping at first error");
    endtask

    // drives the tone registers and the matching model settings
    task automatic set_tone(input fnum_t f, input mult_t m, input block_t b,
                            input waveform_t w, input tl_t t);
        @(posedge clk);
        fnum       <= f;
        mult       <= m;
        block      <= b;
        ws         <= w;
        tl         <= t;
        phase_step  = ((int'(f) * int'(m)) << b) % (1 << PHASE_WIDTH);
        model_ws    = w;
        model_tl    = t;
    endtask

    // pitch high enough that 64 samples cover at least one period
    task automatic random_tone(input waveform_t w);
        logic [31:0] r_fnum;
        logic [31:0] r_mult;
        logic [31:0] r_block;
        logic [31:0] r_tl;
        get_random(9, r_fnum);
        get_random(3, r_mult);
        get_random(1, r_block);
        get_random(3, r_tl);
        set_tone({1'b1, r_fnum[8:0]}, mult_t'(r_mult[2:0]) + 1'b1,
                 block_t'(5 + r_block[0]), w, tl_t'(r_tl[2:0]));
    endtask

    // key-on, collect count samples, key-off and drain the pipeline
    task automatic run_tone(input int count, input logic random_ready, input logic check_gap);
        logic [31:0] r;
        int          quiet;
        int          waited;
        @(posedge clk);
        rx_count  <= 0;
        gap_check <= check_gap;
        @(posedge clk);
        kon <= 1'b1;
        waited = 0;
        while (rx_count < count && waited < count * CLK_DIV_COUNT * 4) begin
            @(posedge clk);
            waited++;
            if (random_ready) begin
                get_random(1, r);
                out_ready <= r[0];
            end
        end
        kon       <= 1'b0;
        out_ready <= 1'b1; // free sink for draining
        gap_check <= 1'b0;
        quiet = 0;
        while (quiet < 4) begin // FIFO and pipeline empty once out_valid stays low
            @(posedge clk);
            quiet = out_valid ? 0 : quiet + 1;
        end
        assert (rx_count >= count)
            else stop_on_error($sformatf("only %0d of %0d samples arrived", rx_count, count));
    endtask

    // output monitor comparing every transfer with the model
    always @(posedge clk) begin
        if (rst) begin
            held_valid <= 1'b0;
        end else begin
            if (held_valid) begin
                assert (out_sample === held_sample)
                    else stop_on_error($sformatf(
                        "Error: out_sample changed in stall, held %h now %h",
                        held_sample, out_sample));
            end
            if (out_valid && out_ready) begin
                expected = op_out_t'(model_sample(rx_count));
                assert (out_sample === expected)
                    else stop_on_error($sformatf(
                        "Error: out_sample #%0d expected %h got %h",
                        rx_count, expected, out_sample));
                if (gap_check && rx_count != 0) begin
                    assert (cycle - last_xfer == CLK_DIV_COUNT)
                        else stop_on_error($sformatf(
                            "Error: out_valid interval expected %h got %h",
                            CLK_DIV_COUNT, cycle - last_xfer));
                end
                rx_count  <= rx_count + 1;
                last_xfer <= cycle;
            end
            held_valid  <= out_valid && !out_ready;
            held_sample <= out_sample;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish in the expected time");
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int          w;
        int          t;
        logic [31:0] r;
        clk        = 1'b0;
        rst        = 1'b1;
        kon        = 1'b0;
        fnum       = '0;
        mult       = '0;
        block      = '0;
        ws         = WAVE_SINE;
        tl         = '0;
        out_ready  = 1'b1;
        lfsr_state = LFSR_SEED;
        phase_step = 0;
        model_ws   = WAVE_SINE;
        model_tl   = '0;
        rx_count   = 0;
        cycle      = 0;
        last_xfer  = 0;
        gap_check  = 1'b0;
        held_valid = 1'b0;
        $readmemh(SINE_FILE, sine_table);
        assert (!$isunknown(sine_table[63]))
            else stop_on_error("the quarter-sine table could not be read");
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // full sine stepping 4 indices per sample over one period
        set_tone(10'h200, 4'd1, 3'd5, WAVE_SINE, 3'd0);
        run_tone(SAMPLES, 1'b0, 1'b1);

        // each waveform in turn with random pitch and level
        for (w = 0; w < 4; w++) begin
            random_tone(waveform_t'(w));
            run_tone(SAMPLES, 1'b0, 1'b0);
        end

        // random sink back-pressure
        get_random(2, r);
        random_tone(waveform_t'(r[1:0]));
        run_tone(SAMPLES, 1'b1, 1'b0);

        // early key-off then restart from phase zero
        random_tone(WAVE_SINE);
        run_tone(10, 1'b1, 1'b0);
        run_tone(SAMPLES, 1'b0, 1'b0);

        // every total level on one fixed pitch
        for (t = 0; t < 8; t++) begin
            set_tone(10'h2a7, 4'd3, 3'd5, WAVE_SINE, tl_t'(t));
            run_tone(SAMPLES, 1'b0, 1'b0);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

//--- project.f
hdl/opl3_pkg.sv
hdl/phase_generator.sv
hdl/phase_fifo.sv
hdl/waveform_generator.sv
hdl/operator_top.sv
test/operator_tb.sv

//--- Bender.yml
package:
  name: opl3_operator

sources:
  - hdl/opl3_pkg.sv
  - hdl/phase_generator.sv
  - hdl/phase_fifo.sv
  - hdl/waveform_generator.sv
  - hdl/operator_top.sv
  - target: test
    files:
      - test/operator_tb.sv

//--- hdl/sine_quarter.hex
// each line holds the 12-bit unsigned quarter-sine magnitude for table addresses 0 to 63 in order
032
097
0FB
15F
1C3
227
28B
2EE
350
3B2
414
475
4D5
534
593
5F1
64D
6A9
704
75E
7B7
80E
864
8B9
90D
95F
9B0
9FF
A4C
A99
AE3
B2C
B73
BB8
BFC
C3D
C7D
CBB
CF7
D31
D69
D9E
DD2
E04
E33
E60
E8B
EB4
EDA
EFE
F20
F40
F5D
F78
F90
FA6
FBA
FCB
FDA
FE6
FF0
FF7
FFC
FFF
